//--- common/ym_timer_defs.svh
// timer slice constants: widths, register addresses, mode bits and dividers
`ifndef YM_DEFS_SVH
`define YM_DEFS_SVH

// counter widths
`define YM_TA_WIDTH 10
`define YM_TB_WIDTH 8

// timer b advances once per 16 ticks
`define YM_TB_PRESCALE_BITS 4

// MCLK cycles per c1/c2 tick
`define YM_PHASE_DIV 4

// register addresses
`define YM_ADDR_TA_HI 8'h24
`define YM_ADDR_TA_LO 8'h25
`define YM_ADDR_TB 8'h26
`define YM_ADDR_MODE 8'h27

// mode register bits
`define YM_MODE_RUN_A 0
`define YM_MODE_RUN_B 1
`define YM_MODE_EN_A 2
`define YM_MODE_EN_B 3
`define YM_MODE_CLR_A 4
`define YM_MODE_CLR_B 5

`endif

//--- common/ym_timer_if.sv
// timer register bundle from the register decoder to the timers and flag logic
`timescale 1ns/1ps
`include "ym_timer_defs.svh"

interface ym_timer_if;

	// reload values
	logic [`YM_TA_WIDTH-1:0] ta_val;
	logic [`YM_TB_WIDTH-1:0] tb_val;

	// mode register levels
	logic run_a;
	logic run_b;
	logic flag_en_a;
	logic flag_en_b;

	// one-cycle pulses from a mode write
	logic flag_clr_a;
	logic flag_clr_b;

	modport decode
	(
		output ta_val,
		output tb_val,
		output run_a,
		output run_b,
		output flag_en_a,
		output flag_en_b,
		output flag_clr_a,
		output flag_clr_b
	);

	modport timer
	(
		input ta_val,
		input tb_val,
		input run_a,
		input run_b
	);

	modport status
	(
		input flag_en_a,
		input flag_en_b,
		input flag_clr_a,
		input flag_clr_b
	);

endinterface

//--- common/ym_timer_pkg.sv
// shared types for the timer slice: register opcodes and clock phases
package ym_timer_pkg;

	// register selected by the latched address
	typedef enum logic [2:0]
	{
		OP_NONE,
		OP_TA_HI,
		OP_TA_LO,
		OP_TB,
		OP_MODE
	} ym_reg_op_e;

	// one tick of the two-phase clock
	typedef enum logic [1:0]
	{
		PH_C1,
		PH_GAP1,
		PH_C2,
		PH_GAP2
	} ym_phase_e;

endpackage

//--- logic/ym_cells.sv
// two-phase storage, counter, trigger and edge cells clocked by c1/c2 strobes
`timescale 1ns/1ps

module ym_sr_bit_array #(parameter int DATA_WIDTH = 1)
(
	input logic MCLK,
	input logic c1,
	input logic c2,
	input logic [DATA_WIDTH-1:0] data_in,
	output logic [DATA_WIDTH-1:0] data_out
);

	// first stage on c1, second stage on c2
	logic [DATA_WIDTH-1:0] stage1 = '0;
	logic [DATA_WIDTH-1:0] stage2 = '0;

	always_ff @(posedge MCLK)
	begin
		if (c1)
			stage1 <= data_in;
		if (c2)
			stage2 <= stage1;
	end

	assign data_out = stage2;

endmodule

module ym_cnt_bit #(parameter int DATA_WIDTH = 1)
(
	input logic MCLK,
	input logic c1,
	input logic c2,
	input logic c_in,
	input logic reset,
	output logic [DATA_WIDTH-1:0] val,
	output logic c_out
);

	logic [DATA_WIDTH-1:0] next_val;
	logic [DATA_WIDTH-1:0] cur_val;
	logic [DATA_WIDTH:0] sum;

	ym_sr_bit_array #(.DATA_WIDTH(DATA_WIDTH)) u_mem
	(
		.MCLK(MCLK),
		.c1(c1),
		.c2(c2),
		.data_in(next_val),
		.data_out(cur_val)
	);

	assign sum = {1'b0, cur_val} + {{DATA_WIDTH{1'b0}}, c_in};
	// cell reset is active high
	assign next_val = reset ? {DATA_WIDTH{1'b0}} : sum[DATA_WIDTH-1:0];
	assign val = cur_val;
	assign c_out = sum[DATA_WIDTH];

endmodule

module ym_cnt_bit_load #(parameter int DATA_WIDTH = 1)
(
	input logic MCLK,
	input logic c1,
	input logic c2,
	input logic c_in,
	input logic reset,
	input logic load,
	input logic [DATA_WIDTH-1:0] load_val,
	output logic [DATA_WIDTH-1:0] val,
	output logic c_out
);

	logic [DATA_WIDTH-1:0] next_val;
	logic [DATA_WIDTH-1:0] cur_val;
	logic [DATA_WIDTH-1:0] base;
	logic [DATA_WIDTH:0] sum;

	ym_sr_bit_array #(.DATA_WIDTH(DATA_WIDTH)) u_mem
	(
		.MCLK(MCLK),
		.c1(c1),
		.c2(c2),
		.data_in(next_val),
		.data_out(cur_val)
	);

	// load replaces the stored value before the carry is added
	assign base = load ? load_val : cur_val;
	assign sum = {1'b0, base} + {{DATA_WIDTH{1'b0}}, c_in};
	assign next_val = reset ? {DATA_WIDTH{1'b0}} : sum[DATA_WIDTH-1:0];
	assign val = cur_val;
	assign c_out = sum[DATA_WIDTH];

endmodule

module ym_rs_trig_sync
(
	input logic MCLK,
	input logic set,
	input logic rst,
	input logic c1,
	output logic q = 1'b0,
	output logic nq = 1'b1
);

	// rst has priority over set
	always_ff @(posedge MCLK)
	begin
		q <= (c1 & rst) ? 1'b0 : ((c1 & set) ? 1'b1 : q);
		nq <= (c1 & rst) ? 1'b1 : ((c1 & set) ? 1'b0 : nq);
	end

endmodule

module ym_edge_detect
(
	input logic MCLK,
	input logic c1,
	input logic inp,
	output logic outp
);

	logic prev = 1'b0;

	// previous level sampled once per tick
	always_ff @(posedge MCLK)
	begin
		if (c1)
			prev <= inp;
	end

	assign outp = inp & ~prev;

endmodule

//--- logic/ym_phase_gen.sv
// phase generator: splits MCLK into non-overlapping c1/c2 strobes, one pair per tick
`timescale 1ns/1ps

module ym_phase_gen
	import ym_timer_pkg::*;
(
	input logic MCLK,
	input logic reset,
	output logic c1,
	output logic c2
);

	ym_phase_e state;

	// gap state in reset keeps both strobes low
	always_ff @(posedge MCLK)
	begin
		if (!reset)
			state <= PH_GAP2;
		else
		begin
			case (state)
				PH_C1: state <= PH_GAP1;
				PH_GAP1: state <= PH_C2;
				PH_C2: state <= PH_GAP2;
				default: state <= PH_C1;
			endcase
		end
	end

	assign c1 = (state == PH_C1);
	assign c2 = (state == PH_C2);

endmodule

//--- logic/ym_timer_top.sv
// timer slice top: phase generator, register decoder, timers a and b and flag logic
`timescale 1ns/1ps
`include "ym_timer_defs.svh"

module ym_timer_top
(
	input logic MCLK,
	input logic reset,
	input logic wr,
	input logic rd,
	input logic a0,
	input logic [7:0] din,
	output logic [7:0] dout,
	output logic irq_n
);

	logic c1;
	logic c2;
	logic ovf_a;
	logic ovf_b;

	ym_timer_if tif();

	ym_phase_gen u_phase
	(
		.MCLK(MCLK),
		.reset(reset),
		.c1(c1),
		.c2(c2)
	);

	ym_reg_decode u_decode
	(
		.MCLK(MCLK),
		.reset(reset),
		.wr(wr),
		.a0(a0),
		.din(din),
		.tif(tif.decode)
	);

	// timer a steps every tick
	ym_timer #(.WIDTH(`YM_TA_WIDTH), .PRESCALE_BITS(0)) u_timer_a
	(
		.MCLK(MCLK),
		.reset(reset),
		.c1(c1),
		.c2(c2),
		.load_val(tif.ta_val),
		.run(tif.run_a),
		.ovf(ovf_a)
	);

	ym_timer #(.WIDTH(`YM_TB_WIDTH), .PRESCALE_BITS(`YM_TB_PRESCALE_BITS)) u_timer_b
	(
		.MCLK(MCLK),
		.reset(reset),
		.c1(c1),
		.c2(c2),
		.load_val(tif.tb_val),
		.run(tif.run_b),
		.ovf(ovf_b)
	);

	ym_timer_status u_status
	(
		.MCLK(MCLK),
		.reset(reset),
		.c1(c1),
		.tif(tif.status),
		.ovf_a(ovf_a),
		.ovf_b(ovf_b),
		.rd(rd),
		.dout(dout),
		.irq_n(irq_n)
	);

endmodule

//--- project.f
+incdir+common
common/ym_timer_pkg.sv
common/ym_timer_if.sv
logic/ym_cells.sv
logic/ym_phase_gen.sv
timers/ym_reg_decode.sv
timers/ym_timer.sv
timers/ym_timer_status.sv
logic/ym_timer_top.sv
sim/tb_ym_timer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the timer slice testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f project.f \
	--top-module tb_ym_timer -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_ym_timer 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "TESTBENCH PASSED"; then
	exit 0
fi
exit 1

//--- sim/tb_ym_timer.sv
// timer slice testbench driving bus writes, status reads, timer windows, flag clear and enables
`timescale 1ns/1ps
`include "ym_timer_defs.svh"

module tb_ym_timer
	import ym_timer_pkg::*;
();

	// worst case cycles per timer test from full-scale overflow plus slack
	localparam int TA_WORST = ((1 << `YM_TA_WIDTH) + 2) * `YM_PHASE_DIV;
	localparam int TB_WORST = ((1 << `YM_TB_WIDTH) + 2) * `YM_PHASE_DIV
		* (1 << `YM_TB_PRESCALE_BITS);
	localparam int TEST_CYCLES = 2 * TA_WORST + TB_WORST + 100;
	localparam int TIMEOUT_CYCLES = (TEST_CYCLES * 3) / 2;

	logic MCLK;
	logic reset;
	logic wr;
	logic rd;
	logic a0;
	logic [7:0] din;
	logic [7:0] dout;
	logic irq_n;

	int errors = 0;
	int checks = 0;
	int cycle_count = 0;
	int ta_value;
	int tb_value;

	ym_timer_top DUT
	(
		.MCLK(MCLK),
		.reset(reset),
		.wr(wr),
		.rd(rd),
		.a0(a0),
		.din(din),
		.dout(dout),
		.irq_n(irq_n)
	);

	initial
	begin
		MCLK = 1'b0;
		forever #5 MCLK = ~MCLK;
	end

	always @(posedge MCLK)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout: run stopped after %0d cycles", cycle_count);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic next_cycle;
		@(posedge MCLK);
		#1;
	endtask

	task automatic check_value(input string name, input int actual, input int expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("FAIL time=%0t %s: got 0x%0h expected 0x%0h", $time, name, actual,
				expected);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	function automatic logic [7:0] reg_addr(input ym_reg_op_e op);
		case (op)
			OP_TA_HI: return `YM_ADDR_TA_HI;
			OP_TA_LO: return `YM_ADDR_TA_LO;
			OP_TB: return `YM_ADDR_TB;
			OP_MODE: return `YM_ADDR_MODE;
			// nothing decodes here
			default: return 8'h30;
		endcase
	endfunction

	function automatic logic [7:0] mode_byte(input bit run_a, input bit run_b,
		input bit en_a, input bit en_b, input bit clr_a, input bit clr_b);
		logic [7:0] m;
		m = 8'h00;
		m[`YM_MODE_RUN_A] = run_a;
		m[`YM_MODE_RUN_B] = run_b;
		m[`YM_MODE_EN_A] = en_a;
		m[`YM_MODE_EN_B] = en_b;
		m[`YM_MODE_CLR_A] = clr_a;
		m[`YM_MODE_CLR_B] = clr_b;
		return m;
	endfunction

	// address byte then data byte back to back
	task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
		next_cycle;
		wr = 1'b1;
		a0 = 1'b0;
		din = addr;
		next_cycle;
		a0 = 1'b1;
		din = data;
		next_cycle;
		wr = 1'b0;
		a0 = 1'b0;
		din = 8'h00;
	endtask

	task automatic read_status(output logic [7:0] data);
		next_cycle;
		rd = 1'b1;
		next_cycle;
		rd = 1'b0;
		data = dout;
	endtask

	// polls the status byte every cycle until the bit rises or the limit runs out
	task automatic wait_status_bit(input int bit_idx, input int limit, output int cycles,
		output bit found);
		cycles = 0;
		found = 1'b0;
		rd = 1'b1;
		while (!found && cycles < limit)
		begin
			next_cycle;
			cycles++;
			if (dout[bit_idx] === 1'b1)
				found = 1'b1;
		end
		rd = 1'b0;
	endtask

	task automatic wait_irq(input logic level, input int limit, inout int cycles);
		int start;
		start = cycles;
		while (irq_n !== level && cycles - start < limit)
		begin
			next_cycle;
			cycles++;
		end
	endtask

	task automatic after_reset_values;
		logic [7:0] status;
		check_value("irq_n", int'(irq_n), 1);
		check_value("dout", int'(dout), 0);
		read_status(status);
		check_value("status", int'(status), 0);
	endtask

	task automatic check_window(input string name, input bit found, input int cycles,
		input int lo, input int hi);
		if (!found)
			report_error($sformatf("%s not set within %0d cycles", name, hi));
		else if (cycles < lo)
			report_error($sformatf("%s set after %0d cycles, before %0d", name, cycles, lo));
	endtask

	task automatic timer_a_window;
		int n_hi;
		int lo;
		int hi;
		int cycles;
		bit found;
		n_hi = int'($urandom % 32'd255);
		ta_value = n_hi * 4 + 3;
		lo = ((1 << `YM_TA_WIDTH) - ta_value - 1) * `YM_PHASE_DIV;
		hi = ((1 << `YM_TA_WIDTH) - ta_value + 2) * `YM_PHASE_DIV;
		write_reg(reg_addr(OP_TA_HI), 8'(n_hi));
		write_reg(reg_addr(OP_TA_LO), 8'h03);
		write_reg(reg_addr(OP_MODE), mode_byte(1, 0, 1, 0, 0, 0));
		wait_status_bit(0, hi, cycles, found);
		check_window("flag A", found, cycles, lo, hi);
		wait_irq(1'b0, hi - cycles, cycles);
		check_value("irq_n", int'(irq_n), 0);
		check_value("status flag B", int'(dout[1]), 0);
	endtask

	task automatic clear_flag_a;
		logic [7:0] status;
		int cycles;
		write_reg(reg_addr(OP_MODE), mode_byte(0, 0, 0, 0, 1, 0));
		read_status(status);
		check_value("status", int'(status), 0);
		cycles = 0;
		wait_irq(1'b1, 2 * `YM_PHASE_DIV, cycles);
		check_value("irq_n", int'(irq_n), 1);
	endtask

	task automatic timer_b_window;
		int lo;
		int hi;
		int cycles;
		int tick_len;
		bit found;
		tb_value = int'($urandom % 32'd256);
		tick_len = `YM_PHASE_DIV * (1 << `YM_TB_PRESCALE_BITS);
		lo = ((1 << `YM_TB_WIDTH) - tb_value - 1) * tick_len;
		hi = ((1 << `YM_TB_WIDTH) - tb_value + 2) * tick_len;
		write_reg(reg_addr(OP_TB), 8'(tb_value));
		write_reg(reg_addr(OP_MODE), mode_byte(0, 1, 0, 1, 0, 0));
		wait_status_bit(1, hi, cycles, found);
		check_window("flag B", found, cycles, lo, hi);
		check_value("status flag A", int'(dout[0]), 0);
	endtask

	task automatic enable_off_period;
		logic [7:0] status;
		int wait_len;
		// flag B is still set from the timer B test
		write_reg(reg_addr(OP_NONE), 8'h3F);
		read_status(status);
		check_value("status", int'(status), 2);
		check_value("irq_n", int'(irq_n), 0);
		// timer A runs with its flag disabled while flag B clears
		write_reg(reg_addr(OP_MODE), mode_byte(1, 0, 0, 0, 0, 1));
		wait_len = ((1 << `YM_TA_WIDTH) - ta_value + 2) * `YM_PHASE_DIV;
		repeat (wait_len) next_cycle;
		read_status(status);
		check_value("status", int'(status), 0);
		check_value("irq_n", int'(irq_n), 1);
	endtask

	initial
	begin
		reset = 1'b0;
		wr = 1'b0;
		rd = 1'b0;
		a0 = 1'b0;
		din = 8'h00;
		void'($urandom(19));
		ta_value = 0;
		tb_value = 0;
		repeat (5) @(posedge MCLK);
		#1;
		reset = 1'b1;

		after_reset_values;
		timer_a_window;
		clear_flag_a;
		timer_b_window;
		enable_off_period;

		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- timers/ym_reg_decode.sv
// register decoder: address latch and data writes into timer reload and mode bits
`timescale 1ns/1ps
`include "ym_timer_defs.svh"

module ym_reg_decode
	import ym_timer_pkg::*;
(
	input logic MCLK,
	input logic reset,
	input logic wr,
	input logic a0,
	input logic [7:0] din,
	ym_timer_if.decode tif
);

	logic [7:0] addr;
	ym_reg_op_e op;

	always_comb
	begin
		case (addr)
			`YM_ADDR_TA_HI: op = OP_TA_HI;
			`YM_ADDR_TA_LO: op = OP_TA_LO;
			`YM_ADDR_TB: op = OP_TB;
			`YM_ADDR_MODE: op = OP_MODE;
			default: op = OP_NONE;
		endcase
	end

	always_ff @(posedge MCLK)
	begin
		if (!reset)
		begin
			addr <= 8'h00;
			tif.ta_val <= '0;
			tif.tb_val <= '0;
			tif.run_a <= 1'b0;
			tif.run_b <= 1'b0;
			tif.flag_en_a <= 1'b0;
			tif.flag_en_b <= 1'b0;
			tif.flag_clr_a <= 1'b0;
			tif.flag_clr_b <= 1'b0;
		end
		else
		begin
			// clear pulses last one cycle
			tif.flag_clr_a <= 1'b0;
			tif.flag_clr_b <= 1'b0;
			if (wr && !a0)
				addr <= din;
			else if (wr && a0)
			begin
				case (op)
					OP_TA_HI: tif.ta_val[`YM_TA_WIDTH-1:2] <= din;
					OP_TA_LO: tif.ta_val[1:0] <= din[1:0];
					OP_TB: tif.tb_val <= din;
					OP_MODE:
					begin
						tif.run_a <= din[`YM_MODE_RUN_A];
						tif.run_b <= din[`YM_MODE_RUN_B];
						tif.flag_en_a <= din[`YM_MODE_EN_A];
						tif.flag_en_b <= din[`YM_MODE_EN_B];
						tif.flag_clr_a <= din[`YM_MODE_CLR_A];
						tif.flag_clr_b <= din[`YM_MODE_CLR_B];
					end
					default: ;
				endcase
			end
		end
	end

endmodule

//--- timers/ym_timer.sv
// interval timer: reloadable up counter with optional prescaler and overflow pulse
`timescale 1ns/1ps

module ym_timer #(parameter int WIDTH = 10, parameter int PRESCALE_BITS = 0)
(
	input logic MCLK,
	input logic reset,
	input logic c1,
	input logic c2,
	input logic [WIDTH-1:0] load_val,
	input logic run,
	output logic ovf
);

	logic step;
	logic run_rise;
	logic cnt_load;
	logic cnt_cout;
	logic wrap_q;

	generate
		if (PRESCALE_BITS > 0)
		begin : g_pre
			// held clear while stopped so the first step is a full period away
			ym_cnt_bit #(.DATA_WIDTH(PRESCALE_BITS)) u_pre
			(
				.MCLK(MCLK),
				.c1(c1),
				.c2(c2),
				.c_in(run),
				.reset(~run | ~reset),
				.val(),
				.c_out(step)
			);
		end
		else
		begin : g_no_pre
			assign step = 1'b1;
		end
	endgenerate

	ym_edge_detect u_run_edge
	(
		.MCLK(MCLK),
		.c1(c1),
		.inp(run),
		.outp(run_rise)
	);

	// reload while stopped, at start, and on the tick after a wrap
	assign cnt_load = ~run | run_rise | wrap_q;

	ym_cnt_bit_load #(.DATA_WIDTH(WIDTH)) u_cnt
	(
		.MCLK(MCLK),
		.c1(c1),
		.c2(c2),
		.c_in(run & step),
		.reset(~reset),
		.load(cnt_load),
		.load_val(load_val),
		.val(),
		.c_out(cnt_cout)
	);

	always_ff @(posedge MCLK)
	begin
		if (!reset)
			wrap_q <= 1'b0;
		else if (c2)
			wrap_q <= run & cnt_cout;
	end

	assign ovf = c2 & run & cnt_cout;

endmodule

//--- timers/ym_timer_status.sv
// timer flags: latched overflow flags, clears, interrupt pin and status byte
`timescale 1ns/1ps

module ym_timer_status
(
	input logic MCLK,
	input logic reset,
	input logic c1,
	ym_timer_if.status tif,
	input logic ovf_a,
	input logic ovf_b,
	input logic rd,
	output logic [7:0] dout,
	output logic irq_n
);

	logic flag_a;
	logic flag_b;
	logic flag_a_n;
	logic flag_b_n;

	// flags follow every MCLK, clear wins inside the trigger
	ym_rs_trig_sync u_flag_a
	(
		.MCLK(MCLK),
		.set(ovf_a & tif.flag_en_a),
		.rst(tif.flag_clr_a | ~reset),
		.c1(1'b1),
		.q(flag_a),
		.nq(flag_a_n)
	);

	ym_rs_trig_sync u_flag_b
	(
		.MCLK(MCLK),
		.set(ovf_b & tif.flag_en_b),
		.rst(tif.flag_clr_b | ~reset),
		.c1(1'b1),
		.q(flag_b),
		.nq(flag_b_n)
	);

	always_ff @(posedge MCLK)
	begin
		if (!reset)
		begin
			dout <= 8'h00;
			irq_n <= 1'b1;
		end
		else
		begin
			if (rd)
				dout <= {6'b000000, flag_b, flag_a};
			// irq pin updates once per tick
			if (c1)
				irq_n <= flag_a_n & flag_b_n;
		end
	end

endmodule
